/* Bender.yml */
package:
  name: matmul

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/matmul_pkg.sv
      - verilog/operand_ram.sv
      - verilog/feed_sequencer.sv
      - verilog/operand_skew.sv
      - verilog/processing_element.sv
      - verilog/systolic_array.sv
      - verilog/matmul_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tests/tb_matmul.sv

/* list.f */
+incdir+verilog
verilog/matmul_pkg.sv
verilog/operand_ram.sv
verilog/feed_sequencer.sv
verilog/operand_skew.sv
verilog/processing_element.sv
verilog/systolic_array.sv
verilog/matmul_top.sv
tests/tb_matmul.sv

/* tests/tb_matmul.sv */
`timescale 1ns/1ps
`include "matmul_macros.svh"

module tb_matmul;

  localparam int DW             = `MM_DWIDTH;
  localparam int RESET_CYCLES   = 3;
  localparam int NUM_RUNS       = 4;
  // host writes per run plus start and stop cycles
  localparam int LOAD_CYCLES    = 2*`MM_N + 2;
  localparam int RUN_CYCLES     = 40;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + 4 + NUM_RUNS*(LOAD_CYCLES + RUN_CYCLES);

  logic                 clk;
  logic                 reset;
  matmul_pkg::host_wr_t wr;
  logic                 start;
  logic                 done;
  matmul_pkg::row_idx_t rd_row;
  matmul_pkg::word_t    c_row;

  // operands and expected result, [row][col]
  matmul_pkg::elem_t mat_a    [`MM_N][`MM_N];
  matmul_pkg::elem_t mat_b    [`MM_N][`MM_N];
  matmul_pkg::elem_t expected [`MM_N][`MM_N];
  // stimulus asks, comparing process clears when finished
  logic check_req;
  int   value_errors;
  int   done_errors;

  matmul_top i_matmul_top (
    .clk      (clk),
    .reset    (reset),
    .i_wr     (wr),
    .i_start  (start),
    .o_done   (done),
    .i_rd_row (rd_row),
    .o_c_row  (c_row)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // next edge, then 1 ns past it
  task automatic wait_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic print_counts();
    $display("errors: %0d o_c_row mismatches, %0d o_done mismatches", value_errors, done_errors);
  endtask

  // C = A x B with 32 bit sums, clipped to the element range
  function automatic void reference_multiply();
    matmul_pkg::acc_t sum;
    for (int i = 0; i < `MM_N; i++) begin
      for (int j = 0; j < `MM_N; j++) begin
        sum = '0;
        for (int k = 0; k < `MM_N; k++) begin
          sum += matmul_pkg::acc_t'(mat_a[i][k]) * matmul_pkg::acc_t'(mat_b[k][j]);
        end
        expected[i][j] = (sum > {DW{1'b1}}) ? {DW{1'b1}} : sum[DW-1:0];
      end
    end
  endfunction

  // A is identity or random below a_limit, B random below b_limit
  task automatic fill_operands(input bit a_identity, input int unsigned a_limit,
                               input int unsigned b_limit);
    for (int i = 0; i < `MM_N; i++) begin
      for (int j = 0; j < `MM_N; j++) begin
        mat_a[i][j] = a_identity ? matmul_pkg::elem_t'(i == j)
                                 : matmul_pkg::elem_t'($urandom % a_limit);
        mat_b[i][j] = matmul_pkg::elem_t'($urandom % b_limit);
      end
    end
  endtask

  // word k of A is column k, word k of B is row k
  task automatic load_memories();
    matmul_pkg::word_t col_a;
    matmul_pkg::word_t row_b;
    for (int k = 0; k < `MM_N; k++) begin
      for (int e = 0; e < `MM_N; e++) begin
        col_a[e*DW +: DW] = mat_a[e][k];
        row_b[e*DW +: DW] = mat_b[k][e];
      end
      wr = '{we_a: 1'b1, we_b: 1'b0, addr: matmul_pkg::addr_t'(k), data: col_a};
      wait_cycle();
      wr = '{we_a: 1'b0, we_b: 1'b1, addr: matmul_pkg::addr_t'(k), data: row_b};
      wait_cycle();
    end
    wr = '0;
  endtask

  task automatic expect_done_low(input string when);
    if (done !== 1'b0) begin
      $display("MISMATCH t=%0t o_done %s expected 0 got %b", $time, when, done);
      done_errors++;
    end
  endtask

  // one full multiply, then stop and check that done drops
  task automatic run_matmul();
    reference_multiply();
    load_memories();
    start = 1'b1;
    // watchdog ends the run if done never comes
    while (done !== 1'b1) begin
      wait_cycle();
    end
    check_req = 1'b1;
    wait (check_req == 1'b0);
    wait_cycle();
    start = 1'b0;
    wait_cycle();
    expect_done_low("after start lowered");
  endtask

  initial begin : compare_results
    matmul_pkg::elem_t got;
    rd_row = '0;
    forever begin
      wait (check_req == 1'b1);
      // every row against the reference
      for (int r = 0; r < `MM_N; r++) begin
        wait_cycle();
        rd_row = matmul_pkg::row_idx_t'(r);
        #1;
        for (int c = 0; c < `MM_N; c++) begin
          got = c_row[c*DW +: DW];
          if (got !== expected[r][c]) begin
            $display("MISMATCH t=%0t o_c_row row %0d col %0d expected %h got %h",
                     $time, r, c, expected[r][c], got);
            value_errors++;
          end
        end
      end
      // done held high, rows must not move
      for (int h = 0; h < 10; h++) begin
        wait_cycle();
        rd_row = matmul_pkg::row_idx_t'(h % `MM_N);
        #1;
        if (done !== 1'b1) begin
          $display("MISMATCH t=%0t o_done while held expected 1 got %b", $time, done);
          done_errors++;
        end
        for (int c = 0; c < `MM_N; c++) begin
          got = c_row[c*DW +: DW];
          if (got !== expected[h % `MM_N][c]) begin
            $display("MISMATCH t=%0t o_c_row hold row %0d col %0d expected %h got %h",
                     $time, h % `MM_N, c, expected[h % `MM_N][c], got);
            value_errors++;
          end
        end
      end
      check_req = 1'b0;
    end
  end

  initial begin : watchdog
    int cycle_cnt;
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    print_counts();
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin : stimulus
    void'($urandom(57));
    reset        = 1'b1;
    start        = 1'b0;
    wr           = '0;
    check_req    = 1'b0;
    value_errors = 0;
    done_errors  = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset = 1'b0;
    expect_done_low("after reset");
    // identity A, result is B
    fill_operands(1'b1, 1, 256);
    run_matmul();
    // 4 x 127 x 127 stays inside 16 bits
    fill_operands(1'b0, 128, 128);
    run_matmul();
    // 15 bit operands, sums saturate but fit 32 bits
    fill_operands(1'b0, 32768, 32768);
    run_matmul();
    // reloaded after a stop, accumulators start from zero
    fill_operands(1'b0, 128, 128);
    run_matmul();
    wait_cycle();
    print_counts();
    if (value_errors + done_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* verilog/feed_sequencer.sv */
`timescale 1ns/1ps
`include "matmul_macros.svh"

module feed_sequencer (
  input  logic              clk,
  input  logic              reset,
  input  logic              i_start,
  output matmul_pkg::addr_t o_rd_addr,
  output logic              o_feed_valid,
  output logic              o_clear,
  output logic              o_done
);

  matmul_pkg::seq_state_t state_q;
  matmul_pkg::cnt_t       cnt_q;
  logic                   rd_valid;
  logic                   feed_valid_q;
  logic                   done_q;

  // words 0..N-1 are read at counts 0..N-1
  // count 0 falls in the idle cycle where start is first seen
  assign rd_valid = i_start && (state_q != matmul_pkg::SEQ_DONE) &&
                    (cnt_q < matmul_pkg::cnt_t'(`MM_N));

  assign o_rd_addr = rd_valid ? matmul_pkg::addr_t'(cnt_q) : '0;

  // state and counter
  // dropping start returns to idle from any state
  always_ff @(posedge clk) begin
    if (reset || !i_start) begin
      state_q <= matmul_pkg::SEQ_IDLE;
      cnt_q   <= '0;
      done_q  <= 1'b0;
    end else begin
      case (state_q)
        matmul_pkg::SEQ_IDLE: begin
          state_q <= matmul_pkg::SEQ_RUN;
          cnt_q   <= cnt_q + 1'b1;
        end
        matmul_pkg::SEQ_RUN: begin
          if (cnt_q == matmul_pkg::cnt_t'(`MM_DONE_COUNT)) begin
            // array fully drained
            state_q <= matmul_pkg::SEQ_DONE;
            done_q  <= 1'b1;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        matmul_pkg::SEQ_DONE: begin
          // hold until start drops
          done_q <= 1'b1;
        end
        default: begin
          state_q <= matmul_pkg::SEQ_IDLE;
        end
      endcase
    end
  end

  // valid follows the read address by the ram latency
  always_ff @(posedge clk) begin
    if (reset) begin
      feed_valid_q <= 1'b0;
    end else begin
      feed_valid_q <= rd_valid;
    end
  end

  assign o_feed_valid = feed_valid_q;

  // skews and accumulators zero while idle or stopping
  assign o_clear = !i_start || (state_q == matmul_pkg::SEQ_IDLE);

  assign o_done = done_q;

endmodule

/* verilog/matmul_macros.svh */
`ifndef MATMUL_MACROS_SVH
`define MATMUL_MACROS_SVH

// element width in bits
`define MM_DWIDTH 16

// array is MM_N x MM_N, also elements per memory word
`define MM_N 4

// operand memory words
`define MM_MEM_DEPTH 16

// address bits for MM_MEM_DEPTH words
`define MM_AWIDTH 4

// last count before done, leaves room for skew plus array drain
`define MM_DONE_COUNT 18

`endif

/* verilog/matmul_pkg.sv */
`include "matmul_macros.svh"

package matmul_pkg;

  // one matrix element
  typedef logic [`MM_DWIDTH-1:0] elem_t;

  // full precision dot product, product width
  typedef logic [2*`MM_DWIDTH-1:0] acc_t;

  // operand memory address
  typedef logic [`MM_AWIDTH-1:0] addr_t;

  // one memory word, element i at bits [i*DW +: DW]
  typedef logic [`MM_N*`MM_DWIDTH-1:0] word_t;

  // result row index
  typedef logic [$clog2(`MM_N)-1:0] row_idx_t;

  // sequencer cycle count
  typedef logic [7:0] cnt_t;

  // host write port, one strobe per memory
  typedef struct packed {
    logic  we_a;
    logic  we_b;
    addr_t addr;
    word_t data;
  } host_wr_t;

  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_RUN,
    SEQ_DONE
  } seq_state_t;

endpackage

/* verilog/matmul_top.sv */
`timescale 1ns/1ps
`include "matmul_macros.svh"

module matmul_top (
  input  logic                 clk,
  input  logic                 reset,
  input  matmul_pkg::host_wr_t i_wr,
  input  logic                 i_start,
  output logic                 o_done,
  input  matmul_pkg::row_idx_t i_rd_row,
  output matmul_pkg::word_t    o_c_row
);

  matmul_pkg::addr_t rd_addr;
  matmul_pkg::word_t a_word;
  matmul_pkg::word_t b_word;
  matmul_pkg::word_t a_lanes;
  matmul_pkg::word_t b_lanes;
  logic              feed_valid;
  logic              clear;

  // word k holds column k of A
  operand_ram u_ram_a (
    .clk       (clk),
    .i_we      (i_wr.we_a),
    .i_wr_addr (i_wr.addr),
    .i_wr_data (i_wr.data),
    .i_rd_addr (rd_addr),
    .o_rd_data (a_word)
  );

  // word k holds row k of B
  operand_ram u_ram_b (
    .clk       (clk),
    .i_we      (i_wr.we_b),
    .i_wr_addr (i_wr.addr),
    .i_wr_data (i_wr.data),
    .i_rd_addr (rd_addr),
    .o_rd_data (b_word)
  );

  // shared address for both memories
  feed_sequencer u_seq (
    .clk          (clk),
    .reset        (reset),
    .i_start      (i_start),
    .o_rd_addr    (rd_addr),
    .o_feed_valid (feed_valid),
    .o_clear      (clear),
    .o_done       (o_done)
  );

  // a lanes go to array rows
  operand_skew u_skew_a (
    .clk     (clk),
    .reset   (reset),
    .i_clear (clear),
    .i_valid (feed_valid),
    .i_word  (a_word),
    .o_lanes (a_lanes)
  );

  // b lanes go to array columns
  operand_skew u_skew_b (
    .clk     (clk),
    .reset   (reset),
    .i_clear (clear),
    .i_valid (feed_valid),
    .i_word  (b_word),
    .o_lanes (b_lanes)
  );

  systolic_array u_array (
    .clk       (clk),
    .reset     (reset),
    .i_clear   (clear),
    .i_a_lanes (a_lanes),
    .i_b_lanes (b_lanes),
    .i_rd_row  (i_rd_row),
    .o_c_row   (o_c_row)
  );

endmodule

/* verilog/operand_ram.sv */
`timescale 1ns/1ps
`include "matmul_macros.svh"

module operand_ram (
  input  logic              clk,
  input  logic              i_we,
  input  matmul_pkg::addr_t i_wr_addr,
  input  matmul_pkg::word_t i_wr_data,
  input  matmul_pkg::addr_t i_rd_addr,
  output matmul_pkg::word_t o_rd_data
);

  // storage, no reset on contents
  matmul_pkg::word_t mem [`MM_MEM_DEPTH];

  // host write port
  always_ff @(posedge clk) begin
    if (i_we) begin
      mem[i_wr_addr] <= i_wr_data;
    end
  end

  // registered read, one cycle latency
  // same address as a write returns the previous word
  always_ff @(posedge clk) begin
    o_rd_data <= mem[i_rd_addr];
  end

endmodule

/* verilog/operand_skew.sv */
`timescale 1ns/1ps
`include "matmul_macros.svh"

module operand_skew (
  input  logic              clk,
  input  logic              reset,
  input  logic              i_clear,
  input  logic              i_valid,
  input  matmul_pkg::word_t i_word,
  output matmul_pkg::word_t o_lanes
);

  matmul_pkg::word_t gated;

  // zero outside the feed window so stale ram data never enters
  assign gated = i_valid ? i_word : '0;

  // lane i goes through i registers
  for (genvar i = 0; i < `MM_N; i++) begin : g_lane
    if (i == 0) begin : g_direct
      // first lane is not delayed
      assign o_lanes[0 +: `MM_DWIDTH] = gated[0 +: `MM_DWIDTH];
    end else begin : g_delay
      matmul_pkg::elem_t pipe_q [i];

      always_ff @(posedge clk) begin
        if (reset || i_clear) begin
          pipe_q <= '{default: '0};
        end else begin
          pipe_q[0] <= gated[i*`MM_DWIDTH +: `MM_DWIDTH];
          for (int s = 1; s < i; s++) begin
            pipe_q[s] <= pipe_q[s-1];
          end
        end
      end

      assign o_lanes[i*`MM_DWIDTH +: `MM_DWIDTH] = pipe_q[i-1];
    end
  end

endmodule

/* verilog/processing_element.sv */
`timescale 1ns/1ps
`include "matmul_macros.svh"

module processing_element (
  input  logic              clk,
  input  logic              reset,
  input  logic              i_clear,
  input  matmul_pkg::elem_t i_a,
  input  matmul_pkg::elem_t i_b,
  output matmul_pkg::elem_t o_a,
  output matmul_pkg::elem_t o_b,
  output matmul_pkg::elem_t o_c
);

  matmul_pkg::acc_t acc_q;
  matmul_pkg::acc_t product;

  // full width product, unsigned
  assign product = matmul_pkg::acc_t'(i_a) * matmul_pkg::acc_t'(i_b);

  // a moves right, b moves down, one stage each
  always_ff @(posedge clk) begin
    if (reset || i_clear) begin
      o_a   <= '0;
      o_b   <= '0;
      acc_q <= '0;
    end else begin
      o_a   <= i_a;
      o_b   <= i_b;
      acc_q <= acc_q + product;
    end
  end

  // saturate to element width
  // any upper bit set reads as all ones
  assign o_c = (|acc_q[2*`MM_DWIDTH-1:`MM_DWIDTH]) ? '1 : acc_q[`MM_DWIDTH-1:0];

endmodule

/* verilog/systolic_array.sv */
`timescale 1ns/1ps
`include "matmul_macros.svh"

module systolic_array (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 i_clear,
  input  matmul_pkg::word_t    i_a_lanes,
  input  matmul_pkg::word_t    i_b_lanes,
  input  matmul_pkg::row_idx_t i_rd_row,
  output matmul_pkg::word_t    o_c_row
);

  // per cell operand inputs and outputs, [row][col]
  matmul_pkg::elem_t a_in  [`MM_N][`MM_N];
  matmul_pkg::elem_t b_in  [`MM_N][`MM_N];
  matmul_pkg::elem_t a_out [`MM_N][`MM_N];
  matmul_pkg::elem_t b_out [`MM_N][`MM_N];
  matmul_pkg::elem_t c_cell [`MM_N][`MM_N];

  for (genvar r = 0; r < `MM_N; r++) begin : g_row
    for (genvar c = 0; c < `MM_N; c++) begin : g_col

      // left edge takes a lane r, inner cells take left neighbour
      if (c == 0) begin : g_a_edge
        assign a_in[r][c] = i_a_lanes[r*`MM_DWIDTH +: `MM_DWIDTH];
      end else begin : g_a_pass
        assign a_in[r][c] = a_out[r][c-1];
      end

      // top edge takes b lane c, inner cells take cell above
      if (r == 0) begin : g_b_edge
        assign b_in[r][c] = i_b_lanes[c*`MM_DWIDTH +: `MM_DWIDTH];
      end else begin : g_b_pass
        assign b_in[r][c] = b_out[r-1][c];
      end

      processing_element u_pe (
        .clk     (clk),
        .reset   (reset),
        .i_clear (i_clear),
        .i_a     (a_in[r][c]),
        .i_b     (b_in[r][c]),
        .o_a     (a_out[r][c]),
        .o_b     (b_out[r][c]),
        .o_c     (c_cell[r][c])
      );
    end
  end

  // row read, column j lands in element j
  always_comb begin
    for (int c = 0; c < `MM_N; c++) begin
      o_c_row[c*`MM_DWIDTH +: `MM_DWIDTH] = c_cell[i_rd_row][c];
    end
  end

endmodule
